// ==== filelist.f ====
verilog/remsi_pkg.sv
verilog/urem_pipeline.sv
verilog/remsi_datapath.sv
verilog/valid_delay.sv
verilog/oehb_dataless.sv
verilog/remsi.sv
bench/remsi_checker.sv
bench/remsi_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module remsi_tb \
		-f filelist.f -o Vremsi_tb
	./obj_dir/Vremsi_tb 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/remsi_tb.sv ====
module remsi_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned clk_period   = 40;
  localparam int unsigned reset_cycles = 10;
  localparam int unsigned n_directed   = 18;
  localparam int unsigned n_random     = 400;
  localparam int unsigned lat          = remsi_pkg::latency;
  // every pair may sit out the whole pipeline plus slack four times over
  localparam int unsigned watchdog_cycles = (n_directed + n_random) * (lat + 8) * 4;

  // sign combinations, most negative dividend, minus one and zero divisors
  localparam remsi_pkg::data_t dir_lhs [n_directed] = '{
    32'd7, 32'hffff_fff9, 32'd7, 32'hffff_fff9,
    32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 32'd5,
    32'hffff_fffb, 32'd3, 32'hffff_fffd, 32'd3,
    32'h7fff_ffff, 32'd100, 32'hffff_ff9c, 32'h8000_0000,
    32'd0, 32'h7fff_ffff
  };
  localparam remsi_pkg::data_t dir_rhs [n_directed] = '{
    32'd3, 32'd3, 32'hffff_fffd, 32'hffff_fffd,
    32'd3, 32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff,
    32'hffff_ffff, 32'd100, 32'd100, 32'h8000_0000,
    32'h8000_0000, 32'd0, 32'd0, 32'd0,
    32'd5, 32'd2
  };

  logic             clk;
  logic             rst_n;
  remsi_pkg::data_t lhs;
  logic             lhs_valid;
  remsi_pkg::data_t rhs;
  logic             rhs_valid;
  logic             result_ready;
  remsi_pkg::data_t result;
  logic             result_valid;
  logic             lhs_ready;
  logic             rhs_ready;

  // scoreboard in acceptance order
  remsi_pkg::data_t expected_q [$];
  remsi_pkg::data_t lhs_q [$];
  remsi_pkg::data_t rhs_q [$];

  int unsigned accepted;
  int unsigned delivered;
  time         first_accept_t;
  time         last_result_t;
  logic        stall_on;

  remsi UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .lhs          (lhs),
    .lhs_valid    (lhs_valid),
    .rhs          (rhs),
    .rhs_valid    (rhs_valid),
    .result_ready (result_ready),
    .result       (result),
    .result_valid (result_valid),
    .lhs_ready    (lhs_ready),
    .rhs_ready    (rhs_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  // signed remainder with C truncation
  // the sign follows the dividend
  function automatic remsi_pkg::data_t ref_rem(input remsi_pkg::data_t a,
                                               input remsi_pkg::data_t b);
    longint sa;
    longint sb;
    longint r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (sb == 0) begin
      return a;
    end
    r = sa % sb;
    return r[31:0];
  endfunction

  // mix of corner values, small signed values and full-range words
  function automatic remsi_pkg::data_t random_operand();
    int unsigned      pick;
    remsi_pkg::data_t v;
    pick = $urandom_range(9);
    v = $urandom_range(40);
    case (pick)
      0: return '0;
      1: return 32'h8000_0000;
      2, 3: return v;
      4: return 32'd0 - v;
      default: return $urandom();
    endcase
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_result(input remsi_pkg::data_t got, input remsi_pkg::data_t want,
                              input remsi_pkg::data_t a, input remsi_pkg::data_t b);
    if (got !== want) begin
      stop_run($sformatf("Fail at %0t: lhs %h rhs %h gave %h, expected %h",
                         $time, a, b, got, want));
    end
  endtask

  // called at a falling edge and returns at the falling edge after the transfer
  task automatic send_pair(input remsi_pkg::data_t a, input remsi_pkg::data_t b);
    int unsigned target;
    target = accepted + 1;
    lhs = a;
    rhs = b;
    lhs_valid = 1'b1;
    rhs_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (accepted != target);
  endtask

  task automatic send_random(input int unsigned n);
    int unsigned sent;
    int unsigned seen;
    sent = 0;
    seen = accepted;
    while (sent < n) begin
      @(negedge clk);
      // pair went in at the last rising edge
      if (accepted != seen) begin
        seen = accepted;
        sent++;
        lhs_valid = 1'b0;
        rhs_valid = 1'b0;
      end
      // each side offers on its own schedule
      if (sent < n && !lhs_valid && $urandom_range(3) != 0) begin
        lhs = random_operand();
        lhs_valid = 1'b1;
      end
      if (sent < n && !rhs_valid && $urandom_range(3) != 0) begin
        rhs = random_operand();
        rhs_valid = 1'b1;
      end
    end
  endtask

  task automatic drive_ready_phases();
    int unsigned phase_len;
    int unsigned stall_pct;
    while (stall_on) begin
      phase_len = $urandom_range(60, 10);
      stall_pct = $urandom_range(90);
      repeat (phase_len) begin
        @(negedge clk);
        if (stall_on) begin
          result_ready = ($urandom_range(99) >= stall_pct);
        end else begin
          result_ready = 1'b1;
        end
      end
    end
    result_ready = 1'b1;
  endtask

  task automatic wait_drain();
    while (expected_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // acceptance monitor
  always @(posedge clk) begin
    if (lhs_valid && lhs_ready && rhs_valid && rhs_ready) begin
      if (accepted == 0) begin
        first_accept_t = $time;
      end
      accepted++;
      expected_q.push_back(ref_rem(lhs, rhs));
      lhs_q.push_back(lhs);
      rhs_q.push_back(rhs);
    end
  end

  always @(posedge clk) begin : compare
    remsi_pkg::data_t want;
    remsi_pkg::data_t a;
    remsi_pkg::data_t b;
    if (rst_n && result_valid && result_ready) begin
      if (expected_q.size() == 0) begin
        stop_run("a result came out while no accepted pair was waiting for it");
      end else if (delivered == 0 && ($time - first_accept_t) != lat * clk_period) begin
        stop_run($sformatf("first result came %0d cycles after acceptance instead of %0d",
                           ($time - first_accept_t) / clk_period, lat));
      end else if (delivered > 0 && delivered < n_directed &&
                   ($time - last_result_t) != clk_period) begin
        // directed pairs stream back to back
        stop_run("directed results did not come back one per cycle");
      end else begin
        want = expected_q.pop_front();
        a = lhs_q.pop_front();
        b = rhs_q.pop_front();
        check_result(result, want, a, b);
        delivered++;
        last_result_t = $time;
      end
    end
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired with %0d of %0d results delivered", delivered, accepted);
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial begin : main_seq
    int i;
    void'($urandom(32'h996a));
    rst_n = 1'b0;
    lhs = '0;
    lhs_valid = 1'b0;
    rhs = '0;
    rhs_valid = 1'b0;
    result_ready = 1'b1;
    stall_on = 1'b0;
    accepted = 0;
    delivered = 0;
    first_accept_t = 0;
    last_result_t = 0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // directed pairs with both valids high and the output always draining
    for (i = 0; i < n_directed; i++) begin
      send_pair(dir_lhs[i], dir_rhs[i]);
    end
    lhs_valid = 1'b0;
    rhs_valid = 1'b0;
    wait_drain();

    // random traffic under phased back-pressure
    stall_on = 1'b1;
    fork
      begin
        send_random(n_random);
        stall_on = 1'b0;
      end
      drive_ready_phases();
    join
    wait_drain();
    repeat (lat + 4) @(posedge clk);

    if (delivered != accepted || expected_q.size() != 0) begin
      $display("%0d pairs accepted but %0d results delivered", accepted, delivered);
      $display("RESULT: FAIL");
      $fatal(1, "result count mismatch");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== bench/remsi_checker.sv ====
module remsi_checker (
  input logic             clk,
  input logic             rst_n,
  input logic             lhs_valid,
  input logic             rhs_valid,
  input logic             lhs_ready,
  input logic             rhs_ready,
  input remsi_pkg::data_t result,
  input logic             result_valid,
  input logic             result_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  // output slot is empty while reset is held
  assert property (@(posedge clk) !rst_n |-> !result_valid)
    else $error("result_valid high during reset");

  // stalled result keeps its valid and its value
  assert property (@(posedge clk) disable iff (!rst_n)
                   result_valid && !result_ready |=> result_valid && $stable(result))
    else $error("result changed while stalled");

  // join takes both operands together
  assert property (@(posedge clk) disable iff (!rst_n) lhs_ready |-> rhs_valid)
    else $error("lhs_ready without rhs_valid");

  assert property (@(posedge clk) disable iff (!rst_n) rhs_ready |-> lhs_valid)
    else $error("rhs_ready without lhs_valid");

endmodule

bind remsi remsi_checker u_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .lhs_valid    (lhs_valid),
  .rhs_valid    (rhs_valid),
  .lhs_ready    (lhs_ready),
  .rhs_ready    (rhs_ready),
  .result       (result),
  .result_valid (result_valid),
  .result_ready (result_ready)
);

// ==== verilog/remsi.sv ====
module remsi (
  input  logic              clk,
  input  logic              rst_n,
  input  remsi_pkg::data_t  lhs,
  input  logic              lhs_valid,
  input  remsi_pkg::data_t  rhs,
  input  logic              rhs_valid,
  input  logic              result_ready,
  output remsi_pkg::data_t  result,
  output logic              result_valid,
  output logic              lhs_ready,
  output logic              rhs_ready
);

  // shared pipeline enable from the output buffer
  logic ce;

  // joined valid after the shift line
  logic delayed_valid;

  valid_delay u_valid_delay (
    .clk       (clk),
    .rst_n     (rst_n),
    .ce        (ce),
    .lhs_valid (lhs_valid),
    .rhs_valid (rhs_valid),
    .lhs_ready (lhs_ready),
    .rhs_ready (rhs_ready),
    .valid_out (delayed_valid)
  );

  remsi_datapath u_datapath (
    .clk    (clk),
    .ce     (ce),
    .lhs    (lhs),
    .rhs    (rhs),
    .result (result)
  );

  oehb_dataless u_oehb (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_in     (delayed_valid),
    .result_ready (result_ready),
    .result_valid (result_valid),
    .ce           (ce)
  );

endmodule

// ==== verilog/oehb_dataless.sv ====
module oehb_dataless (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_in,
  input  logic result_ready,
  output logic result_valid,
  output logic ce
);

  // advance when the slot is empty or being drained this cycle
  assign ce = ~result_valid | result_ready;

  // registered output valid
  // holds while the consumer stalls
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else if (ce) begin
      result_valid <= valid_in;
    end
  end

endmodule

// ==== verilog/valid_delay.sv ====
module valid_delay (
  input  logic clk,
  input  logic rst_n,
  input  logic ce,
  input  logic lhs_valid,
  input  logic rhs_valid,
  output logic lhs_ready,
  output logic rhs_ready,
  output logic valid_out
);

  localparam int unsigned len = remsi_pkg::valid_delay_len;

  logic           join_valid;
  logic [len-1:0] valid_line_q;

  // both operands are needed before anything enters
  assign join_valid = lhs_valid & rhs_valid;

  // each side is ready only when the other side is offering too
  // the pair is taken in a single cycle
  assign lhs_ready = ce & rhs_valid;
  assign rhs_ready = ce & lhs_valid;

  // valid tokens follow the data with one flop per enabled cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_line_q <= '0;
    end else if (ce) begin
      valid_line_q <= {valid_line_q[len-2:0], join_valid};
    end
  end

  assign valid_out = valid_line_q[len-1];

endmodule

// ==== verilog/remsi_datapath.sv ====
module remsi_datapath (
  input  logic              clk,
  input  logic              ce,
  input  remsi_pkg::data_t  lhs,
  input  remsi_pkg::data_t  rhs,
  output remsi_pkg::data_t  result
);

  localparam int unsigned w = remsi_pkg::data_width;
  localparam int unsigned n = remsi_pkg::div_stages;

  // magnitudes ahead of the input register
  remsi_pkg::data_t lhs_mag;
  remsi_pkg::data_t rhs_mag;

  // input register
  remsi_pkg::data_t lhs_mag_q;
  remsi_pkg::data_t rhs_mag_q;
  logic             lhs_sign_q;

  // dividend sign kept in step with the divider stages
  logic [n-1:0]     sign_line_q;

  remsi_pkg::data_t remd;

  // two's complement negate for negative operands
  // 0x80000000 maps onto itself as the right unsigned magnitude
  assign lhs_mag = lhs[w-1] ? (~lhs + 1'b1) : lhs;
  assign rhs_mag = rhs[w-1] ? (~rhs + 1'b1) : rhs;

  always_ff @(posedge clk) begin
    if (ce) begin
      lhs_mag_q  <= lhs_mag;
      rhs_mag_q  <= rhs_mag;
      lhs_sign_q <= lhs[w-1];
    end
  end

  urem_pipeline u_urem (
    .clk      (clk),
    .ce       (ce),
    .dividend (lhs_mag_q),
    .divisor  (rhs_mag_q),
    .remd     (remd)
  );

  always_ff @(posedge clk) begin
    if (ce) begin
      sign_line_q <= {sign_line_q[n-2:0], lhs_sign_q};
    end
  end

  // output register
  // remainder follows the sign of the dividend
  always_ff @(posedge clk) begin
    if (ce) begin
      if (sign_line_q[n-1]) begin
        result <= ~remd + 1'b1;
      end else begin
        result <= remd;
      end
    end
  end

endmodule

// ==== verilog/urem_pipeline.sv ====
module urem_pipeline (
  input  logic              clk,
  input  logic              ce,
  input  remsi_pkg::data_t  dividend,
  input  remsi_pkg::data_t  divisor,
  output remsi_pkg::data_t  remd
);

  localparam int unsigned w = remsi_pkg::data_width;
  localparam int unsigned n = remsi_pkg::div_stages;

  genvar i;
  generate
    for (i = 0; i < n; i = i + 1) begin : g_stage

      // values entering this iteration
      remsi_pkg::data_t dvd_in;
      remsi_pkg::data_t dvs_in;
      remsi_pkg::data_t rem_in;

      // shifted partial remainder and trial difference
      remsi_pkg::data_t shifted;
      logic [w:0]       diff;
      logic             borrow;

      // stage registers
      // dvd_q also collects the quotient bits from the right
      remsi_pkg::data_t dvd_q;
      remsi_pkg::data_t dvs_q;
      remsi_pkg::data_t rem_q;

      if (i == 0) begin : g_first
        // stage 0 starts from the operands and an empty remainder
        assign dvd_in = dividend;
        assign dvs_in = divisor;
        assign rem_in = '0;
      end else begin : g_rest
        assign dvd_in = g_stage[i-1].dvd_q;
        assign dvs_in = g_stage[i-1].dvs_q;
        assign rem_in = g_stage[i-1].rem_q;
      end

      // bring down the next dividend bit
      assign shifted = {rem_in[w-2:0], dvd_in[w-1]};

      // an extra top bit catches the borrow
      assign diff   = {1'b0, shifted} - {1'b0, dvs_in};
      assign borrow = diff[w];

      always_ff @(posedge clk) begin
        if (ce) begin
          // quotient bit is set when the subtraction fits
          dvd_q <= {dvd_in[w-2:0], ~borrow};
          dvs_q <= dvs_in;
          // restore on borrow, otherwise keep the difference
          if (borrow) begin
            rem_q <= shifted;
          end else begin
            rem_q <= diff[w-1:0];
          end
        end
      end

    end
  endgenerate

  // final partial remainder is the unsigned remainder
  assign remd = g_stage[n-1].rem_q;

endmodule

// ==== verilog/remsi_pkg.sv ====
package remsi_pkg;

  // operand and result width of one machine word
  localparam int unsigned data_width = 32;

  // signed operands travel as plain vectors
  // the datapath handles the sign
  typedef logic [data_width-1:0] data_t;

  // one restoring iteration per dividend bit
  localparam int unsigned div_stages = data_width;

  // enabled cycles from acceptance to result_valid
  // input register plus the iteration stages plus output register
  localparam int unsigned latency = div_stages + 2;

  // depth of the valid shift line
  // the output buffer flop supplies the final cycle
  localparam int unsigned valid_delay_len = latency - 1;

endpackage
